// ==== compile.f ====
hdl/mem_pkg.sv
hdl/cache_ram.sv
hdl/dcache.sv
hdl/fetch_port.sv
hdl/bus_arbiter.sv
hdl/memory_subsystem.sv
verif/tb_clock.sv
verif/memory_subsystem_sva.sv
verif/tb_memory_subsystem.sv

// ==== hdl/bus_arbiter.sv ====
// Round-robin bus arbiter.
// Grants the data cache or the fetch port and keeps the grant
// until the bus returns ready.

`timescale 1ns/1ns

module bus_arbiter import mem_pkg::*; (
	input  logic     i_clock,
	input  logic     i_reset,
	input  bus_req_t i_dc_req,
	input  bus_req_t i_if_req,
	output bus_rsp_t o_dc_rsp,
	output bus_rsp_t o_if_rsp,
	output bus_req_t o_bus_req,
	input  bus_rsp_t i_bus_rsp
);

	typedef enum logic [1:0] {
		OWN_NONE,
		OWN_DC,
		OWN_IF
	} owner_t;

	owner_t owner, next_owner;

	// Set when the fetch side got the last transfer.
	logic last_if;
	logic grant_dc, grant_if;

	always_comb begin
		grant_dc = 1'b0;
		grant_if = 1'b0;
		case (owner)
			OWN_DC: grant_dc = 1'b1;
			OWN_IF: grant_if = 1'b1;
			default: begin
				if (i_dc_req.request && i_if_req.request) begin
					grant_dc = last_if;
					grant_if = !last_if;
				end else begin
					grant_dc = i_dc_req.request;
					grant_if = i_if_req.request;
				end
			end
		endcase
	end

	// Lock on a new grant unless it finished in the same cycle.
	always_comb begin
		next_owner = owner;
		if (i_bus_rsp.ready) begin
			next_owner = OWN_NONE;
		end else if (grant_dc) begin
			next_owner = OWN_DC;
		end else if (grant_if) begin
			next_owner = OWN_IF;
		end
	end

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			owner <= OWN_NONE;
			last_if <= 1'b0;
		end else begin
			owner <= next_owner;
			if (i_bus_rsp.ready && (grant_dc || grant_if)) begin
				last_if <= grant_if;
			end
		end
	end

	always_comb begin
		o_bus_req = '0;
		if (grant_dc) begin
			o_bus_req = i_dc_req;
		end else if (grant_if) begin
			o_bus_req = i_if_req;
		end
		o_dc_rsp = '{ready: grant_dc && i_bus_rsp.ready, rdata: i_bus_rsp.rdata};
		o_if_rsp = '{ready: grant_if && i_bus_rsp.ready, rdata: i_bus_rsp.rdata};
	end

endmodule

// ==== hdl/cache_ram.sv ====
// Cache entry RAM.
// Single port, read every cycle with one cycle of latency.

`timescale 1ns/1ns

module cache_ram import mem_pkg::*; #(
	parameter int INDEX_WIDTH = 10
) (
	input  logic                   i_clock,
	input  logic                   i_rw,
	input  logic [INDEX_WIDTH-1:0] i_address,
	input  cache_entry_t           i_wdata,
	output cache_entry_t           o_rdata
);

	cache_entry_t mem [2**INDEX_WIDTH];

	// Read-first; output shows the old entry on a write.
	always_ff @(posedge i_clock) begin
		if (i_rw) begin
			mem[i_address] <= i_wdata;
		end
		o_rdata <= mem[i_address];
	end

endmodule

// ==== hdl/dcache.sv ====
// Data cache.
// Direct-mapped, write-back, one word per line. Initializes after
// reset, flushes dirty lines on request, passes uncacheable accesses.

`timescale 1ns/1ns

module dcache import mem_pkg::*; #(
	parameter int INDEX_WIDTH = 10
) (
	input  logic     i_clock,
	input  logic     i_reset,
	input  logic     i_request,
	input  logic     i_rw,
	input  logic     i_flush,
	input  logic     i_cacheable,
	input  addr_t    i_address,
	input  word_t    i_wdata,
	output logic     o_ready,
	output word_t    o_rdata,
	output bus_req_t o_bus_req,
	input  bus_rsp_t i_bus_rsp
);

	typedef enum logic [3:0] {
		INITIALIZE,
		IDLE,
		FLUSH_SETUP,
		FLUSH_CHECK,
		FLUSH_WRITE,
		FLUSH_NEXT,
		PASS_THROUGH,
		WRITE_SETUP,
		WRITE_WAIT,
		READ_SETUP,
		READ_WB_WAIT,
		READ_BUS_WAIT
	} state_t;

	state_t state, next_state;

	// Shared by init and flush; top bit set means all lines visited.
	logic [INDEX_WIDTH:0] flush_index, next_index;

	logic                   ram_rw;
	logic [INDEX_WIDTH-1:0] ram_address;
	cache_entry_t           ram_wdata;
	cache_entry_t           entry;

	addr_t victim_address;
	logic  tag_match;

	function automatic bus_req_t bus_write(addr_t address, word_t wdata);
		return '{request: 1'b1, rw: 1'b1, address: address, wdata: wdata};
	endfunction

	function automatic bus_req_t bus_read(addr_t address);
		return '{request: 1'b1, rw: 1'b0, address: address, wdata: '0};
	endfunction

	cache_ram #(
		.INDEX_WIDTH(INDEX_WIDTH)
	) u_cache_ram (
		.i_clock  (i_clock),
		.i_rw     (ram_rw),
		.i_address(ram_address),
		.i_wdata  (ram_wdata),
		.o_rdata  (entry)
	);

	assign victim_address = {entry.tag, 2'b00};
	assign tag_match = (entry.tag == i_address[31:2]);

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			state <= INITIALIZE;
			flush_index <= '0;
		end else begin
			state <= next_state;
			flush_index <= next_index;
		end
	end

	always_comb begin
		next_state = state;
		next_index = flush_index;
		o_ready = 1'b0;
		o_rdata = entry.data;
		o_bus_req = '0;
		ram_rw = 1'b0;
		ram_wdata = '0;
		ram_address = i_address[INDEX_WIDTH+1:2];

		case (state)
			// ========================================
			// Initialize and dispatch
			// ========================================

			// Zero entry is invalid and clean.
			INITIALIZE: begin
				ram_address = flush_index[INDEX_WIDTH-1:0];
				if (!flush_index[INDEX_WIDTH]) begin
					ram_rw = 1'b1;
					next_index = flush_index + 1'b1;
				end else begin
					next_index = '0;
					next_state = IDLE;
				end
			end

			IDLE: begin
				if (i_request) begin
					if (i_flush) begin
						next_index = '0;
						next_state = FLUSH_SETUP;
					end else if (!i_cacheable) begin
						next_state = PASS_THROUGH;
					end else if (i_rw) begin
						next_state = WRITE_SETUP;
					end else begin
						next_state = READ_SETUP;
					end
				end
			end

			// ========================================
			// Flush
			// ========================================

			FLUSH_SETUP: begin
				ram_address = flush_index[INDEX_WIDTH-1:0];
				if (!flush_index[INDEX_WIDTH]) begin
					next_state = FLUSH_CHECK;
				end else begin
					o_ready = 1'b1;
					next_state = IDLE;
				end
			end

			FLUSH_CHECK: begin
				ram_address = flush_index[INDEX_WIDTH-1:0];
				if (entry.dirty) begin
					o_bus_req = bus_write(victim_address, entry.data);
					next_state = FLUSH_WRITE;
				end else begin
					next_index = flush_index + 1'b1;
					next_state = FLUSH_SETUP;
				end
			end

			// Entry stays put; mark it clean once written.
			FLUSH_WRITE: begin
				ram_address = flush_index[INDEX_WIDTH-1:0];
				o_bus_req = bus_write(victim_address, entry.data);
				if (i_bus_rsp.ready) begin
					ram_rw = 1'b1;
					ram_wdata = entry;
					ram_wdata.dirty = 1'b0;
					next_state = FLUSH_NEXT;
				end
			end

			FLUSH_NEXT: begin
				next_index = flush_index + 1'b1;
				next_state = FLUSH_SETUP;
			end

			// ========================================
			// Uncacheable
			// ========================================

			// Straight to the bus, back to idle when the request drops.
			PASS_THROUGH: begin
				o_bus_req = '{request: i_request, rw: i_rw, address: i_address,
					wdata: i_wdata};
				o_rdata = i_bus_rsp.rdata;
				o_ready = i_bus_rsp.ready;
				if (!i_request) begin
					next_state = IDLE;
				end
			end

			// ========================================
			// Write
			// ========================================

			WRITE_SETUP: begin
				if (entry.dirty && !tag_match) begin
					o_bus_req = bus_write(victim_address, entry.data);
					next_state = WRITE_WAIT;
				end else begin
					ram_rw = 1'b1;
					ram_wdata = '{data: i_wdata, tag: i_address[31:2], dirty: 1'b1,
						valid: 1'b1};
					o_ready = 1'b1;
					next_state = IDLE;
				end
			end

			WRITE_WAIT: begin
				o_bus_req = bus_write(victim_address, entry.data);
				if (i_bus_rsp.ready) begin
					ram_rw = 1'b1;
					ram_wdata = '{data: i_wdata, tag: i_address[31:2], dirty: 1'b1,
						valid: 1'b1};
					o_ready = 1'b1;
					next_state = IDLE;
				end
			end

			// ========================================
			// Read
			// ========================================

			READ_SETUP: begin
				if (entry.valid && tag_match) begin
					o_ready = 1'b1;
					next_state = IDLE;
				end else if (entry.dirty) begin
					o_bus_req = bus_write(victim_address, entry.data);
					next_state = READ_WB_WAIT;
				end else begin
					o_bus_req = bus_read(i_address);
					next_state = READ_BUS_WAIT;
				end
			end

			// Victim out first.
			READ_WB_WAIT: begin
				o_bus_req = bus_write(victim_address, entry.data);
				if (i_bus_rsp.ready) begin
					next_state = READ_BUS_WAIT;
				end
			end

			READ_BUS_WAIT: begin
				o_bus_req = bus_read(i_address);
				o_rdata = i_bus_rsp.rdata;
				if (i_bus_rsp.ready) begin
					ram_rw = 1'b1;
					ram_wdata = '{data: i_bus_rsp.rdata, tag: i_address[31:2],
						dirty: 1'b0, valid: 1'b1};
					o_ready = 1'b1;
					next_state = IDLE;
				end
			end

			default: begin
				next_state = IDLE;
			end
		endcase
	end

endmodule

// ==== hdl/fetch_port.sv ====
// Instruction fetch port.
// Keeps the last fetched word and answers repeats without the bus.

`timescale 1ns/1ns

module fetch_port import mem_pkg::*; (
	input  logic     i_clock,
	input  logic     i_reset,
	input  logic     i_request,
	input  addr_t    i_address,
	output logic     o_ready,
	output word_t    o_rdata,
	output bus_req_t o_bus_req,
	input  bus_rsp_t i_bus_rsp
);

	typedef enum logic [1:0] {
		IDLE,
		FETCH,
		RESPOND
	} state_t;

	state_t state;

	logic  buf_valid;
	addr_t buf_address;
	word_t buf_data;

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			state <= IDLE;
			buf_valid <= 1'b0;
		end else begin
			case (state)
				IDLE: begin
					if (i_request) begin
						if (buf_valid && buf_address == i_address) begin
							state <= RESPOND;
						end else begin
							state <= FETCH;
						end
					end
				end
				FETCH: begin
					if (i_bus_rsp.ready) begin
						buf_valid <= 1'b1;
						state <= RESPOND;
					end
				end
				default: begin
					state <= IDLE;
				end
			endcase
		end
	end

	// Refill payload.
	always_ff @(posedge i_clock) begin
		if (state == FETCH && i_bus_rsp.ready) begin
			buf_address <= i_address;
			buf_data <= i_bus_rsp.rdata;
		end
	end

	assign o_ready = (state == RESPOND);
	assign o_rdata = buf_data;
	assign o_bus_req = '{request: state == FETCH, rw: 1'b0, address: i_address, wdata: '0};

endmodule

// ==== hdl/mem_pkg.sv ====
// Memory subsystem package.
// Word, address and cache entry types, plus the request and
// response structs of the shared memory bus.

package mem_pkg;

	// ========================================
	// Plain vector types
	// ========================================

	typedef logic [31:0] word_t;
	typedef logic [31:0] addr_t;

	// Upper 30 bits of a word-aligned address.
	typedef logic [29:0] tag_t;

	// ========================================
	// Cache line
	// ========================================

	typedef struct packed {
		word_t data;
		tag_t  tag;
		logic  dirty;
		logic  valid;
	} cache_entry_t;

	// ========================================
	// Memory bus
	// ========================================

	// Held stable by the master until ready.
	typedef struct packed {
		logic  request;
		logic  rw;
		addr_t address;
		word_t wdata;
	} bus_req_t;

	typedef struct packed {
		logic  ready;
		word_t rdata;
	} bus_rsp_t;

endpackage

// ==== hdl/memory_subsystem.sv ====
// Memory subsystem top level.
// Data cache and fetch port sharing one memory bus via an arbiter.

`timescale 1ns/1ns

module memory_subsystem import mem_pkg::*; #(
	parameter int INDEX_WIDTH = 10
) (
	input  logic     i_clock,
	input  logic     i_reset,

	// Data port.
	input  logic     i_dc_request,
	input  logic     i_dc_rw,
	input  logic     i_dc_flush,
	input  logic     i_dc_cacheable,
	input  addr_t    i_dc_address,
	input  word_t    i_dc_wdata,
	output logic     o_dc_ready,
	output word_t    o_dc_rdata,

	// Fetch port.
	input  logic     i_if_request,
	input  addr_t    i_if_address,
	output logic     o_if_ready,
	output word_t    o_if_rdata,

	// Memory bus.
	output bus_req_t o_bus_req,
	input  bus_rsp_t i_bus_rsp
);

	bus_req_t dc_bus_req;
	bus_rsp_t dc_bus_rsp;
	bus_req_t if_bus_req;
	bus_rsp_t if_bus_rsp;

	dcache #(
		.INDEX_WIDTH(INDEX_WIDTH)
	) u_dcache (
		.i_clock    (i_clock),
		.i_reset    (i_reset),
		.i_request  (i_dc_request),
		.i_rw       (i_dc_rw),
		.i_flush    (i_dc_flush),
		.i_cacheable(i_dc_cacheable),
		.i_address  (i_dc_address),
		.i_wdata    (i_dc_wdata),
		.o_ready    (o_dc_ready),
		.o_rdata    (o_dc_rdata),
		.o_bus_req  (dc_bus_req),
		.i_bus_rsp  (dc_bus_rsp)
	);

	fetch_port u_fetch_port (
		.i_clock  (i_clock),
		.i_reset  (i_reset),
		.i_request(i_if_request),
		.i_address(i_if_address),
		.o_ready  (o_if_ready),
		.o_rdata  (o_if_rdata),
		.o_bus_req(if_bus_req),
		.i_bus_rsp(if_bus_rsp)
	);

	bus_arbiter u_bus_arbiter (
		.i_clock  (i_clock),
		.i_reset  (i_reset),
		.i_dc_req (dc_bus_req),
		.i_if_req (if_bus_req),
		.o_dc_rsp (dc_bus_rsp),
		.o_if_rsp (if_bus_rsp),
		.o_bus_req(o_bus_req),
		.i_bus_rsp(i_bus_rsp)
	);

endmodule

// ==== verif/memory_subsystem_sva.sv ====
// Bus and arbiter protocol checks.
// Bound into the arbiter; counts every assertion failure.

`timescale 1ns/1ns

module memory_subsystem_sva import mem_pkg::*; (
	input logic     i_clock,
	input logic     i_reset,
	input bus_req_t i_dc_req,
	input bus_req_t i_if_req,
	input bus_rsp_t i_dc_rsp,
	input bus_rsp_t i_if_rsp,
	input bus_req_t i_bus_req,
	input bus_rsp_t i_bus_rsp
);

	int unsigned failure_count = 0;

	// Outer request held unchanged until the bus answers.
	a_request_stable: assert property (@(posedge i_clock) disable iff (i_reset)
		i_bus_req.request && !i_bus_rsp.ready |=> $stable(i_bus_req))
	else begin
		$error("Outer bus request changed before ready");
		failure_count++;
	end

	// Ready only reaches a requesting client.
	a_dc_ready_requested: assert property (@(posedge i_clock) disable iff (i_reset)
		i_dc_rsp.ready |-> i_dc_req.request)
	else begin
		$error("Data side saw ready without a request");
		failure_count++;
	end

	a_if_ready_requested: assert property (@(posedge i_clock) disable iff (i_reset)
		i_if_rsp.ready |-> i_if_req.request)
	else begin
		$error("Fetch side saw ready without a request");
		failure_count++;
	end

	a_ready_exclusive: assert property (@(posedge i_clock) disable iff (i_reset)
		!(i_dc_rsp.ready && i_if_rsp.ready))
	else begin
		$error("Both clients saw ready together");
		failure_count++;
	end

endmodule

bind bus_arbiter memory_subsystem_sva u_sva (
	.i_clock  (i_clock),
	.i_reset  (i_reset),
	.i_dc_req (i_dc_req),
	.i_if_req (i_if_req),
	.i_dc_rsp (o_dc_rsp),
	.i_if_rsp (o_if_rsp),
	.i_bus_req(o_bus_req),
	.i_bus_rsp(i_bus_rsp)
);

// ==== verif/tb_clock.sv ====
// Testbench clock source.
// Free-running clock, starts low.

`timescale 1ns/1ns

module tb_clock #(
	parameter int PERIOD = 100
) (
	output logic o_clock
);

	initial begin
		o_clock = 1'b0;
		forever #(PERIOD / 2) o_clock = ~o_clock;
	end

endmodule

// ==== verif/tb_memory_subsystem.sv ====
// Memory subsystem testbench.
// Bus memory model with random wait states, reference memory,
// data and fetch stimulus, compare process and watchdog.

`timescale 1ns/1ns

module tb_memory_subsystem import mem_pkg::*; ;

	localparam int INDEX_WIDTH = 4;
	localparam int CLOCK_PERIOD = 100;
	localparam int DRIVE_DELAY = 10;
	localparam int MEM_WORDS = 256;
	localparam int READ_ONLY_BASE = 192;
	localparam int PHASE_COUNT = 6;
	localparam int PHASE_CYCLES = 2000;
	localparam int READY_LIMIT = 500;
	localparam int RANDOM_OPS = 100;
	localparam int MIXED_OPS = 60;
	localparam int FETCH_OPS = 40;

	typedef enum logic [1:0] {
		EXP_READ,
		EXP_WRITE,
		EXP_UNCACHED_WRITE,
		EXP_FLUSH
	} expect_kind_t;

	typedef struct packed {
		expect_kind_t kind;
		addr_t        address;
		word_t        data;
	} expect_t;

	logic     clock;
	logic     reset;
	logic     dc_request;
	logic     dc_rw;
	logic     dc_flush;
	logic     dc_cacheable;
	addr_t    dc_address;
	word_t    dc_wdata;
	logic     dc_ready;
	word_t    dc_rdata;
	logic     if_request;
	addr_t    if_address;
	logic     if_ready;
	word_t    if_rdata;
	bus_req_t bus_req;
	bus_rsp_t bus_rsp;

	word_t bus_mem [MEM_WORDS];
	word_t ref_mem [MEM_WORDS];
	logic  written [MEM_WORDS];

	expect_t dc_expect_q [$];
	word_t   if_expect_q [$];

	logic [31:0] lfsr_state = 32'h4ae7;
	logic        bus_busy;
	int          bus_wait;

	logic  mixed_rw [MIXED_OPS];
	addr_t mixed_address [MIXED_OPS];
	word_t mixed_wdata [MIXED_OPS];
	addr_t fetch_address [FETCH_OPS];

	tb_clock #(
		.PERIOD(CLOCK_PERIOD)
	) u_tb_clock (
		.o_clock(clock)
	);

	memory_subsystem #(
		.INDEX_WIDTH(INDEX_WIDTH)
	) UUT (
		.i_clock       (clock),
		.i_reset       (reset),
		.i_dc_request  (dc_request),
		.i_dc_rw       (dc_rw),
		.i_dc_flush    (dc_flush),
		.i_dc_cacheable(dc_cacheable),
		.i_dc_address  (dc_address),
		.i_dc_wdata    (dc_wdata),
		.o_dc_ready    (dc_ready),
		.o_dc_rdata    (dc_rdata),
		.i_if_request  (if_request),
		.i_if_address  (if_address),
		.o_if_ready    (if_ready),
		.o_if_rdata    (if_rdata),
		.o_bus_req     (bus_req),
		.i_bus_rsp     (bus_rsp)
	);

	// ========================================
	// Random numbers and reference model
	// ========================================

	// Taps 32, 22, 2, 1.
	function automatic logic [31:0] lfsr_step(input logic [31:0] state);
		logic feedback;
		feedback = state[31] ^ state[21] ^ state[1] ^ state[0];
		return {state[30:0], feedback};
	endfunction

	task automatic random_bits(input int count, output logic [31:0] value);
		value = '0;
		for (int i = 0; i < count; i++) begin
			lfsr_state = lfsr_step(lfsr_state);
			value = {value[30:0], lfsr_state[0]};
		end
	endtask

	function automatic word_t ref_read(input addr_t address);
		return ref_mem[address[9:2]];
	endfunction

	// Words 0 to 63, so four tags share each line.
	task automatic pick_cached_address(output addr_t address);
		logic [31:0] draw;
		random_bits(6, draw);
		address = {24'h0, draw[5:0], 2'b00};
	endtask

	task automatic pick_uncached_address(output addr_t address);
		logic [31:0] draw;
		random_bits(6, draw);
		address = {22'h0, 2'b10, draw[5:0], 2'b00};
	endtask

	// Few fetch addresses so repeats hit the buffer.
	task automatic pick_fetch_address(output addr_t address);
		logic [31:0] draw;
		random_bits(3, draw);
		address = {22'h0, 2'b11, 3'b000, draw[2:0], 2'b00};
	endtask

	// ========================================
	// Checks
	// ========================================

	task automatic stop_with_failure();
		$display("SIMULATION FAILED");
		$fatal(1, "Stopped at the first error");
	endtask

	task automatic abort_run(input string reason);
		$display("%s at time %0t", reason, $time);
		stop_with_failure();
	endtask

	task automatic check_word(input string name, input word_t actual, input word_t expected);
		if (actual !== expected) begin
			$display("Fail time=%0t %s got %h expected %h", $time, name, actual, expected);
			stop_with_failure();
		end
	endtask

	task automatic check_bit(input string name, input logic actual, input logic expected);
		if (actual !== expected) begin
			$display("Fail time=%0t %s got %b expected %b", $time, name, actual, expected);
			stop_with_failure();
		end
	endtask

	task automatic expect_quiet_outputs();
		check_bit("o_bus_req.request", bus_req.request, 1'b0);
		check_bit("o_dc_ready", dc_ready, 1'b0);
		check_bit("o_if_ready", if_ready, 1'b0);
	endtask

	task automatic compare_flushed();
		for (int i = 0; i < MEM_WORDS; i++) begin
			if (written[i]) begin
				check_word($sformatf("bus_mem[%0d]", i), bus_mem[i], ref_mem[i]);
			end
		end
	endtask

	// ========================================
	// Client stimulus
	// ========================================

	// Records the expected result, then drives the data port.
	task automatic issue_data(input logic rw, input logic cacheable, input logic flush,
		input addr_t address, input word_t wdata);
		expect_t expected;
		expected.address = address;
		expected.data = rw ? wdata : ref_read(address);
		if (flush) begin
			expected.kind = EXP_FLUSH;
		end else if (!rw) begin
			expected.kind = EXP_READ;
		end else if (cacheable) begin
			expected.kind = EXP_WRITE;
		end else begin
			expected.kind = EXP_UNCACHED_WRITE;
		end
		if (rw && !flush) begin
			ref_mem[address[9:2]] = wdata;
			written[address[9:2]] = 1'b1;
		end
		dc_expect_q.push_back(expected);
		dc_request = 1'b1;
		dc_rw = rw;
		dc_flush = flush;
		dc_cacheable = cacheable;
		dc_address = address;
		dc_wdata = wdata;
	endtask

	// Nonzero ready_edge fixes the edge where ready must first show.
	task automatic wait_data_ready(input int ready_edge);
		int cycles;
		cycles = 0;
		do begin
			@(posedge clock);
			cycles++;
			if (cycles <= ready_edge) begin
				check_bit("o_dc_ready", dc_ready, cycles == ready_edge);
			end
			if (cycles > READY_LIMIT) begin
				abort_run("Data port gave no ready");
			end
		end while (!dc_ready);
		#DRIVE_DELAY;
		dc_request = 1'b0;
		dc_rw = 1'b0;
		dc_flush = 1'b0;
		dc_cacheable = 1'b0;
	endtask

	task automatic data_access(input logic rw, input logic cacheable, input logic flush,
		input addr_t address, input word_t wdata, input int ready_edge);
		@(posedge clock);
		#DRIVE_DELAY;
		issue_data(rw, cacheable, flush, address, wdata);
		wait_data_ready(ready_edge);
	endtask

	// A buffer hit must answer on the second edge without the bus.
	task automatic fetch_access(input addr_t address, input logic from_buffer);
		int cycles;
		@(posedge clock);
		#DRIVE_DELAY;
		if_expect_q.push_back(ref_read(address));
		if_request = 1'b1;
		if_address = address;
		cycles = 0;
		do begin
			@(posedge clock);
			cycles++;
			if (from_buffer) begin
				check_bit("o_bus_req.request", bus_req.request, 1'b0);
				check_bit("o_if_ready", if_ready, cycles == 2);
			end
			if (cycles > READY_LIMIT) begin
				abort_run("Fetch port gave no ready");
			end
		end while (!if_ready);
		#DRIVE_DELAY;
		if_request = 1'b0;
	endtask

	// ========================================
	// Bus memory model
	// ========================================

	// Decides at the edge, drives the response a little later.
	always @(posedge clock) begin
		bus_rsp_t    next_rsp;
		logic [31:0] draw;
		int          word_index;
		next_rsp = bus_rsp;
		if (reset) begin
			next_rsp = '0;
			bus_busy = 1'b0;
		end else if (bus_rsp.ready) begin
			next_rsp.ready = 1'b0;
			bus_busy = 1'b0;
		end else if (bus_req.request) begin
			if (!bus_busy) begin
				random_bits(2, draw);
				bus_wait = draw[1:0];
				bus_busy = 1'b1;
			end
			if (bus_wait == 0) begin
				word_index = bus_req.address[9:2];
				if (bus_req.address[31:10] != '0) begin
					abort_run("Bus address outside the memory model");
				end else if (bus_req.rw && word_index >= READ_ONLY_BASE) begin
					abort_run("Bus write into the read-only region");
				end else if (bus_req.rw) begin
					bus_mem[word_index] = bus_req.wdata;
				end else begin
					next_rsp.rdata = bus_mem[word_index];
				end
				next_rsp.ready = 1'b1;
			end else begin
				bus_wait--;
			end
		end
		#DRIVE_DELAY;
		bus_rsp = next_rsp;
	end

	// ========================================
	// Compare process and watchdog
	// ========================================

	always @(posedge clock) begin
		expect_t expected;
		if (!reset) begin
			if (dc_ready) begin
				if (dc_expect_q.size() == 0) begin
					abort_run("Data port ready with no access pending");
				end else begin
					expected = dc_expect_q.pop_front();
					case (expected.kind)
						EXP_READ: check_word("o_dc_rdata", dc_rdata, expected.data);
						EXP_UNCACHED_WRITE: begin
							check_word("bus memory", bus_mem[expected.address[9:2]],
								expected.data);
						end
						EXP_FLUSH: compare_flushed();
						default: begin
						end
					endcase
				end
			end
			if (if_ready) begin
				if (if_expect_q.size() == 0) begin
					abort_run("Fetch port ready with no fetch pending");
				end else begin
					check_word("o_if_rdata", if_rdata, if_expect_q.pop_front());
				end
			end
			if (UUT.u_bus_arbiter.u_sva.failure_count != 0) begin
				abort_run("Bus protocol assertion failed");
			end
		end
	end

	initial begin
		#(PHASE_COUNT * PHASE_CYCLES * CLOCK_PERIOD);
		abort_run("Watchdog expired, the run took too long");
	end

	// ========================================
	// Test sequence
	// ========================================

	initial begin
		addr_t       address;
		word_t       wdata;
		logic [31:0] draw;

		reset = 1'b1;
		dc_request = 1'b0;
		dc_rw = 1'b0;
		dc_flush = 1'b0;
		dc_cacheable = 1'b0;
		dc_address = '0;
		dc_wdata = '0;
		if_request = 1'b0;
		if_address = '0;
		bus_rsp = '0;
		bus_busy = 1'b0;
		bus_wait = 0;

		// Address mixed into the pattern.
		for (int i = 0; i < MEM_WORDS; i++) begin
			random_bits(32, draw);
			bus_mem[i] = draw ^ {i[7:0], 16'h0, i[7:0]};
			ref_mem[i] = bus_mem[i];
			written[i] = 1'b0;
		end

		// Reset and initialization, with a read held from release.
		for (int i = 0; i < 10; i++) begin
			@(posedge clock);
			if (i > 0) begin
				expect_quiet_outputs();
			end
		end
		#DRIVE_DELAY;
		reset = 1'b0;
		pick_cached_address(address);
		issue_data(1'b0, 1'b1, 1'b0, address, '0);
		repeat (2**INDEX_WIDTH + 1) begin
			@(posedge clock);
			expect_quiet_outputs();
		end
		wait_data_ready(0);

		// Random cacheable traffic.
		for (int i = 0; i < RANDOM_OPS; i++) begin
			pick_cached_address(address);
			random_bits(1, draw);
			random_bits(32, wdata);
			data_access(draw[0], 1'b1, 1'b0, address, wdata, 0);
		end

		// Read hits right after a write.
		for (int i = 0; i < 16; i++) begin
			pick_cached_address(address);
			random_bits(32, wdata);
			data_access(1'b1, 1'b1, 1'b0, address, wdata, 0);
			data_access(1'b0, 1'b1, 1'b0, address, '0, 2);
		end

		// Uncacheable region.
		for (int i = 0; i < 24; i++) begin
			pick_uncached_address(address);
			random_bits(1, draw);
			random_bits(32, wdata);
			data_access(draw[0], 1'b0, 1'b0, address, wdata, 0);
		end

		data_access(1'b0, 1'b1, 1'b1, '0, '0, 0);

		// Fetches while the data side is busy.
		for (int i = 0; i < MIXED_OPS; i++) begin
			pick_cached_address(mixed_address[i]);
			random_bits(1, draw);
			mixed_rw[i] = draw[0];
			random_bits(32, mixed_wdata[i]);
		end
		for (int i = 0; i < FETCH_OPS; i++) begin
			pick_fetch_address(fetch_address[i]);
		end
		fork
			begin
				for (int i = 0; i < MIXED_OPS; i++) begin
					data_access(mixed_rw[i], 1'b1, 1'b0, mixed_address[i], mixed_wdata[i], 0);
				end
			end
			begin
				for (int i = 0; i < FETCH_OPS; i++) begin
					fetch_access(fetch_address[i], 1'b0);
				end
			end
		join

		pick_fetch_address(address);
		fetch_access(address, 1'b0);
		fetch_access(address, 1'b1);
		data_access(1'b0, 1'b1, 1'b1, '0, '0, 0);

		repeat (2) @(posedge clock);
		if (dc_expect_q.size() != 0 || if_expect_q.size() != 0) begin
			abort_run("Accesses ended without a ready pulse");
		end
		if (UUT.u_bus_arbiter.u_sva.failure_count == 0) begin
			$display("SIMULATION PASSED");
		end else begin
			$display("SIMULATION FAILED");
		end
		$finish;
	end

endmodule
